//--- hw/merge_config.svh
`ifndef MERGE_CONFIG_SVH
`define MERGE_CONFIG_SVH

// ------------------------------
// Datapath sizing
// ------------------------------
`define MERGE_SAMPLE_W      16
`define MERGE_IN_DEPTH      8
`define MERGE_OUT_DEPTH     4

// FIFO thresholds
`define MERGE_IN_AF_THRESH  (`MERGE_IN_DEPTH - 2)
`define MERGE_IN_AE_THRESH  1
`define MERGE_OUT_AF_THRESH (`MERGE_OUT_DEPTH - 1)  // Leaves room for the word in flight
`define MERGE_OUT_AE_THRESH 1

// ------------------------------
// Register word addresses
// ------------------------------
`define MERGE_REG_DATA      2'd0
`define MERGE_REG_STATUS    2'd1
`define MERGE_REG_DROPS     2'd2

`endif

//--- hw/merge_pkg.sv
`include "merge_config.svh"

package merge_pkg;

    // ------------------------------
    // Sample path
    // ------------------------------

    // One raw producer sample
    typedef struct packed {
        logic [`MERGE_SAMPLE_W-1:0] data;
    } sample_t;

    // Merged word as stored in the output FIFO
    typedef struct packed {
        logic    valid;   // Set on every pushed word
        logic    tag;     // Source channel
        sample_t sample;
    } merged_t;

    // ------------------------------
    // Wishbone classic host port
    // ------------------------------

    // Host to slave
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [1:0]  adr;   // Word address
        logic [31:0] dat;
    } wb_req_t;

    // Slave to host
    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

endpackage

//--- hw/sync_fifo.sv
module sync_fifo #(
    parameter type T                   = logic [7:0],
    parameter int  DEPTH               = 16,
    parameter int  ALMOST_FULL_THRESH  = 14,
    parameter int  ALMOST_EMPTY_THRESH = 2
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   wr_en,
    input  T                       wr_data,
    input  logic                   rd_en,
    output T                       rd_data,
    output logic                   full,
    output logic                   empty,
    output logic                   almost_full,
    output logic                   almost_empty,
    output logic                   overflow,
    output logic [$clog2(DEPTH):0] count    // Spans 0 to DEPTH
);

    localparam int AW = $clog2(DEPTH);
    localparam int CW = AW + 1;

    T              mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count_nxt;   // Count after this edge
    logic          do_wr;       // Accepted push
    logic          do_rd;       // Accepted pop

    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;

    // Wraps at DEPTH so odd depths work too
    function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] p);
        if (p == AW'(DEPTH - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    // ------------------------------
    // Storage and read port
    // ------------------------------
    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
        if (do_rd) begin
            rd_data <= mem[rd_ptr];   // Valid the cycle after the pop
        end
    end

    // Pointers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (do_rd) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
        end
    end

    // ------------------------------
    // Occupancy
    // ------------------------------
    always_comb begin
        case ({do_wr, do_rd})
            2'b10:   count_nxt = count + 1'b1;   // Push only
            2'b01:   count_nxt = count - 1'b1;   // Pop only
            default: count_nxt = count;          // Idle or both
        endcase
    end

    // Flags from next count so they track count without lag
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count        <= '0;
            full         <= 1'b0;
            empty        <= 1'b1;
            almost_full  <= 1'b0;
            almost_empty <= 1'b0;
            overflow     <= 1'b0;
        end else begin
            count        <= count_nxt;
            full         <= (count_nxt == CW'(DEPTH));
            empty        <= (count_nxt == '0);
            almost_full  <= (count_nxt >= ALMOST_FULL_THRESH);
            almost_empty <= (count_nxt <= ALMOST_EMPTY_THRESH);
            overflow     <= wr_en && full;   // Dropped push
        end
    end

    // ------------------------------
    // Checks
    // ------------------------------
    a_count_bound: assert property (@(posedge clk) disable iff (!rst_n)
        count <= DEPTH)
        else $error("sync_fifo count %0d above depth %0d", count, DEPTH);

    a_flags_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(empty && full))
        else $error("sync_fifo empty and full together");

endmodule

//--- hw/rr_merge.sv
module rr_merge
    import merge_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    ch0_empty,
    input  logic    ch1_empty,
    input  logic    out_almost_full,
    input  sample_t ch0_data,          // Input FIFO read data
    input  sample_t ch1_data,
    output logic    ch0_pop,
    output logic    ch1_pop,
    output logic    out_push,
    output merged_t out_word
);

    logic last_ch;       // Channel served by the most recent pop
    logic pick_ch;       // Channel chosen this cycle
    logic can_pop;
    logic inflight;      // Pop issued last cycle
    logic inflight_ch;   // Its source channel

    // ------------------------------
    // Arbitration
    // ------------------------------
    always_comb begin
        if (!ch0_empty && !ch1_empty) begin
            pick_ch = ~last_ch;   // Both ready so take turns
        end else begin
            pick_ch = ch0_empty;  // Only one candidate
        end
    end

    // Stall on output back-pressure
    assign can_pop = !out_almost_full && !(ch0_empty && ch1_empty);

    assign ch0_pop = can_pop && !pick_ch;
    assign ch1_pop = can_pop && pick_ch;

    // ------------------------------
    // Pop tracking
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_ch     <= 1'b1;   // Channel 0 goes first
            inflight    <= 1'b0;
            inflight_ch <= 1'b0;
        end else begin
            inflight <= can_pop;
            if (can_pop) begin
                inflight_ch <= pick_ch;
                last_ch     <= pick_ch;
            end
        end
    end

    // ------------------------------
    // Tagged push
    // ------------------------------

    // Input rd_data is valid the cycle after its pop
    assign out_push        = inflight;
    assign out_word.valid  = inflight;
    assign out_word.tag    = inflight_ch;
    assign out_word.sample = inflight_ch ? ch1_data : ch0_data;

    // Checks
    a_one_pop: assert property (@(posedge clk) disable iff (!rst_n)
        !(ch0_pop && ch1_pop))
        else $error("rr_merge popped both channels");

endmodule

//--- hw/wb_merge_regs.sv
`include "merge_config.svh"

module wb_merge_regs
    import merge_pkg::*;
(
    input  logic                              clk,
    input  logic                              rst_n,
    input  wb_req_t                           wb_req,
    output wb_rsp_t                           wb_rsp,
    input  merged_t                           out_data,      // Output FIFO rd_data
    input  logic                              out_empty,
    input  logic                              out_full,
    input  logic                              ch0_overflow,
    input  logic                              ch1_overflow,
    input  logic [$clog2(`MERGE_OUT_DEPTH):0] out_count,
    input  logic [$clog2(`MERGE_IN_DEPTH):0]  ch0_count,
    input  logic [$clog2(`MERGE_IN_DEPTH):0]  ch1_count,
    output logic                              out_pop
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_DATA,   // Popped word arriving
        ST_ACK
    } state_t;

    state_t      state;
    logic        req_new;      // Strobe seen while idle
    logic        hit_data;
    logic        hit_drops;
    logic        clr_drops;
    logic [15:0] ch0_drops;
    logic [15:0] ch1_drops;
    logic [31:0] status_word;
    logic [31:0] rd_mux;
    logic [31:0] rsp_dat;

    // ------------------------------
    // Decode
    // ------------------------------
    assign req_new   = (state == ST_IDLE) && wb_req.cyc && wb_req.stb;
    assign hit_data  = (wb_req.adr == `MERGE_REG_DATA);
    assign hit_drops = (wb_req.adr == `MERGE_REG_DROPS);

    assign out_pop   = req_new && hit_data && !wb_req.we && !out_empty;
    assign clr_drops = req_new && hit_drops && wb_req.we;   // Any write value

    // STATUS layout
    assign status_word = {18'd0, out_full, out_empty,
                          4'(ch1_count), 4'(ch0_count), 4'(out_count)};

    always_comb begin
        case (wb_req.adr)
            `MERGE_REG_STATUS: rd_mux = status_word;
            `MERGE_REG_DROPS:  rd_mux = {ch1_drops, ch0_drops};
            default:           rd_mux = 32'd0;   // Empty DATA read or hole
        endcase
    end

    // Tag at bit 17 and valid at bit 16
    function automatic logic [31:0] to_word(input merged_t w);
        return 32'({w.tag, w.valid, w.sample});
    endfunction

    // Saturating drop count
    function automatic logic [15:0] sat_inc(input logic [15:0] c, input logic hit);
        if (hit && (c != 16'hffff)) begin
            return c + 1'b1;
        end
        return c;
    endfunction

    // ------------------------------
    // Bus FSM
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (req_new) begin
                        state <= out_pop ? ST_DATA : ST_ACK;
                    end
                end
                ST_DATA: state <= ST_ACK;
                default: state <= ST_IDLE;   // Single-cycle ack
            endcase
        end
    end

    // Read data captured one cycle ahead of ack
    always_ff @(posedge clk) begin
        if (state == ST_DATA) begin
            rsp_dat <= to_word(out_data);
        end else if (req_new) begin
            rsp_dat <= rd_mux;
        end
    end

    assign wb_rsp.ack = (state == ST_ACK);
    assign wb_rsp.dat = rsp_dat;

    // ------------------------------
    // Drop counters
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ch0_drops <= '0;
            ch1_drops <= '0;
        end else if (clr_drops) begin
            ch0_drops <= '0;   // Clear wins over a same-cycle drop
            ch1_drops <= '0;
        end else begin
            ch0_drops <= sat_inc(ch0_drops, ch0_overflow);
            ch1_drops <= sat_inc(ch1_drops, ch1_overflow);
        end
    end

    // Checks
    a_ack_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        wb_rsp.ack |=> !wb_rsp.ack)
        else $error("wb_merge_regs ack held past one cycle");

endmodule

//--- hw/sample_merge_top.sv
`include "merge_config.svh"

module sample_merge_top
    import merge_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    ch0_push,
    input  logic    ch1_push,
    input  sample_t ch0_sample,
    input  sample_t ch1_sample,
    output logic    ch0_full,
    output logic    ch1_full,
    input  wb_req_t wb_req,
    output wb_rsp_t wb_rsp
);

    // ------------------------------
    // Interconnect
    // ------------------------------
    sample_t ch0_rd;              // Input FIFO read data
    sample_t ch1_rd;
    logic    ch0_empty;
    logic    ch1_empty;
    logic    ch0_pop;
    logic    ch1_pop;
    logic    ch0_overflow;
    logic    ch1_overflow;
    logic    [$clog2(`MERGE_IN_DEPTH):0] ch0_count;
    logic    [$clog2(`MERGE_IN_DEPTH):0] ch1_count;
    merged_t out_word;            // Merger to output FIFO
    merged_t out_data;            // Output FIFO to slave
    logic    out_push;
    logic    out_pop;
    logic    out_empty;
    logic    out_full;
    logic    out_almost_full;     // Merger back-pressure
    logic    [$clog2(`MERGE_OUT_DEPTH):0] out_count;

    // Producer side FIFOs
    sync_fifo #(
        .T                   (sample_t),
        .DEPTH               (`MERGE_IN_DEPTH),
        .ALMOST_FULL_THRESH  (`MERGE_IN_AF_THRESH),
        .ALMOST_EMPTY_THRESH (`MERGE_IN_AE_THRESH)
    ) in_fifo0 (
        .clk, .rst_n,
        .wr_en        (ch0_push),
        .wr_data      (ch0_sample),
        .rd_en        (ch0_pop),
        .rd_data      (ch0_rd),
        .full         (ch0_full),
        .empty        (ch0_empty),
        .almost_full  (),
        .almost_empty (),
        .overflow     (ch0_overflow),
        .count        (ch0_count)
    );

    sync_fifo #(
        .T                   (sample_t),
        .DEPTH               (`MERGE_IN_DEPTH),
        .ALMOST_FULL_THRESH  (`MERGE_IN_AF_THRESH),
        .ALMOST_EMPTY_THRESH (`MERGE_IN_AE_THRESH)
    ) in_fifo1 (
        .clk, .rst_n,
        .wr_en        (ch1_push),
        .wr_data      (ch1_sample),
        .rd_en        (ch1_pop),
        .rd_data      (ch1_rd),
        .full         (ch1_full),
        .empty        (ch1_empty),
        .almost_full  (),
        .almost_empty (),
        .overflow     (ch1_overflow),
        .count        (ch1_count)
    );

    // Round-robin merge
    rr_merge u_rr_merge (
        .clk, .rst_n,
        .ch0_empty, .ch1_empty, .out_almost_full,
        .ch0_data (ch0_rd),
        .ch1_data (ch1_rd),
        .ch0_pop, .ch1_pop, .out_push, .out_word
    );

    // Merged words toward the host
    sync_fifo #(
        .T                   (merged_t),
        .DEPTH               (`MERGE_OUT_DEPTH),
        .ALMOST_FULL_THRESH  (`MERGE_OUT_AF_THRESH),
        .ALMOST_EMPTY_THRESH (`MERGE_OUT_AE_THRESH)
    ) out_fifo (
        .clk, .rst_n,
        .wr_en        (out_push),
        .wr_data      (out_word),
        .rd_en        (out_pop),
        .rd_data      (out_data),
        .full         (out_full),
        .empty        (out_empty),
        .almost_full  (out_almost_full),
        .almost_empty (),
        .overflow     (),          // Merger never overfills
        .count        (out_count)
    );

    // Host registers
    wb_merge_regs u_regs (
        .clk, .rst_n,
        .wb_req, .wb_rsp,
        .out_data, .out_empty, .out_full,
        .ch0_overflow, .ch1_overflow,
        .out_count, .ch0_count, .ch1_count,
        .out_pop
    );

endmodule

//--- bench/merge_tb.sv
`include "merge_config.svh"

module merge_tb
    import merge_pkg::*;
();

    localparam int N_ROWS     = 7;
    localparam int BUS_LIMIT  = 20;    // Cycles to wait for ack
    localparam int POLL_LIMIT = 60;    // STATUS reads per poll
    localparam int READ_LIMIT = 300;   // DATA reads per drain

    logic    clk;
    logic    rst_n;
    logic    ch0_push;
    logic    ch1_push;
    sample_t ch0_sample;
    sample_t ch1_sample;
    logic    ch0_full;
    logic    ch1_full;
    wb_req_t wb_req;
    wb_rsp_t wb_rsp;

    int          errors;
    int          checks;
    logic [15:0] exp0 [$];      // Channel 0 samples still owed
    logic [15:0] exp1 [$];
    logic        exp_tag [$];   // Tag order, back-pressure rows only

    // ------------------------------
    // Stimulus table
    // ------------------------------
    string row_name [N_ROWS] = '{"single_ch0", "both_even", "uneven", "rr_backpressure",
                                 "rr_uneven", "drop_ch0", "drop_both"};
    int    row_n0   [N_ROWS] = '{3, 6, 8, 6, 7, 11, 10};   // Channel 0 pushes
    int    row_n1   [N_ROWS] = '{0, 6, 2, 6, 3, 4, 13};
    bit    row_hold [N_ROWS] = '{0, 0, 0, 1, 1, 1, 1};     // Reads wait for full load
    int    row_d0   [N_ROWS] = '{0, 0, 0, 0, 0, 3, 2};     // Expected drops
    int    row_d1   [N_ROWS] = '{0, 0, 0, 0, 0, 0, 5};

    sample_merge_top dut0 (
        .clk, .rst_n,
        .ch0_push, .ch1_push,
        .ch0_sample, .ch1_sample,
        .ch0_full, .ch1_full,
        .wb_req, .wb_rsp
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("FAILED %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
        end
    endtask

    // Timeouts end the run at once
    task automatic abort_run(input string why);
        errors++;
        $display("ERROR: %s", why);
        $display("Checks: %0d, errors: %0d", checks, errors);
        $display("Simulation finished: FAIL");
        $finish;
    endtask

    // ------------------------------
    // Wishbone classic host
    // ------------------------------
    task automatic wb_read(input logic [1:0] adr, output logic [31:0] data);
        int n;
        @(posedge clk);
        #1;
        wb_req     = '0;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.adr = adr;
        for (n = 0; n < BUS_LIMIT && !wb_rsp.ack; n++) begin
            @(posedge clk);
            #1;   // Ack is settled here
        end
        if (!wb_rsp.ack) begin
            abort_run($sformatf("no ack for read of register %0d", adr));
        end
        data = wb_rsp.dat;
        @(posedge clk);   // Strobe drops the cycle after ack
        #1;
        wb_req = '0;
    endtask

    task automatic wb_write(input logic [1:0] adr, input logic [31:0] data);
        int n;
        @(posedge clk);
        #1;
        wb_req     = '0;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = 1'b1;
        wb_req.adr = adr;
        wb_req.dat = data;
        for (n = 0; n < BUS_LIMIT && !wb_rsp.ack; n++) begin
            @(posedge clk);
            #1;
        end
        if (!wb_rsp.ack) begin
            abort_run($sformatf("no ack for write of register %0d", adr));
        end
        @(posedge clk);
        #1;
        wb_req = '0;
    endtask

    // Polls STATUS until the masked fields match
    task automatic wait_status(input logic [31:0] mask, input logic [31:0] value,
                               input string what);
        logic [31:0] st;
        int          n;
        st = 32'd0;
        for (n = 0; n < POLL_LIMIT; n++) begin
            wb_read(`MERGE_REG_STATUS, st);
            if ((st & mask) == value) break;
        end
        if ((st & mask) != value) begin
            abort_run($sformatf("STATUS never showed %s, last 0x%08h", what, st));
        end
    endtask

    // ------------------------------
    // Producers and scoreboard
    // ------------------------------

    // Both channels side by side, one push per cycle
    task automatic push_burst(input int n0, input int n1, input bit hold);
        logic [15:0] s0;
        logic [15:0] s1;
        for (int i = 0; i < n0 || i < n1; i++) begin
            @(posedge clk);
            #1;
            s0              = 16'($urandom);
            s1              = 16'($urandom);
            ch0_push        = (i < n0);
            ch1_push        = (i < n1);
            ch0_sample.data = s0;
            ch1_sample.data = s1;
            // Held FIFO keeps only its depth
            if (i < n0 && (!hold || i < `MERGE_IN_DEPTH)) begin
                exp0.push_back(s0);
            end
            if (i < n1 && (!hold || i < `MERGE_IN_DEPTH)) begin
                exp1.push_back(s1);
            end
        end
        @(posedge clk);
        #1;
        ch0_push = 1'b0;
        ch1_push = 1'b0;
    endtask

    // Pairs while both channels hold words, then the longer one's rest
    function automatic void expect_rr_order(input int s0, input int s1);
        int pairs;
        pairs = (s0 < s1) ? s0 : s1;
        for (int i = 0; i < pairs; i++) begin
            exp_tag.push_back(1'b1);   // Channel 0 went last so channel 1 leads
            exp_tag.push_back(1'b0);
        end
        for (int i = pairs; i < s0; i++) begin
            exp_tag.push_back(1'b0);
        end
        for (int i = pairs; i < s1; i++) begin
            exp_tag.push_back(1'b1);
        end
    endfunction

    task automatic drain(input string name, input bit check_order, input int words);
        logic [31:0] w;
        int          tries;
        tries = 0;
        while (words > 0) begin
            if (tries == READ_LIMIT) begin
                abort_run($sformatf("%s still missing %0d merged words", name, words));
            end
            tries++;
            wb_read(`MERGE_REG_DATA, w);
            if (w[16]) begin   // Valid word
                words--;
                if (check_order) begin
                    check({name, " tag"}, 32'(exp_tag.pop_front()), 32'(w[17]));
                end
                if (!w[17] && exp0.size() > 0) begin
                    check({name, " ch0 sample"}, 32'(exp0.pop_front()), 32'(w[15:0]));
                end else if (w[17] && exp1.size() > 0) begin
                    check({name, " ch1 sample"}, 32'(exp1.pop_front()), 32'(w[15:0]));
                end else begin
                    errors++;
                    $display("ERROR: %s got an extra word from channel %0d", name, w[17]);
                end
            end
        end
    endtask

    // ------------------------------
    // One table row
    // ------------------------------
    task automatic run_row(input int r);
        logic [31:0] rd;
        logic [31:0] st;
        int          s0;
        int          s1;
        string       name;
        name = row_name[r];
        if (row_hold[r]) begin
            s0 = (row_n0[r] < `MERGE_IN_DEPTH) ? row_n0[r] : `MERGE_IN_DEPTH;
            s1 = (row_n1[r] < `MERGE_IN_DEPTH) ? row_n1[r] : `MERGE_IN_DEPTH;
            // Channel 0 alone fills the output FIFO, full set and empty clear
            push_burst(`MERGE_OUT_DEPTH, 0, 1'b0);
            wait_status(32'h0000_30ff, 32'h0000_2000 | `MERGE_OUT_DEPTH,
                        "output FIFO full");
            push_burst(row_n0[r], row_n1[r], 1'b1);
            wait_status(32'h0000_0ff0, (s1 << 8) | (s0 << 4), "input FIFOs loaded");
            check({name, " ch0 full"}, 32'(s0 == `MERGE_IN_DEPTH), 32'(ch0_full));
            check({name, " ch1 full"}, 32'(s1 == `MERGE_IN_DEPTH), 32'(ch1_full));
            repeat (`MERGE_OUT_DEPTH) exp_tag.push_back(1'b0);
            expect_rr_order(s0, s1);
            drain(name, 1'b1, `MERGE_OUT_DEPTH + s0 + s1);
        end else begin
            fork
                push_burst(row_n0[r], row_n1[r], 1'b0);
                drain(name, 1'b0, row_n0[r] + row_n1[r]);
            join
        end

        // Drop counters then clear
        wb_read(`MERGE_REG_DROPS, rd);
        check({name, " drops"}, {16'(row_d1[r]), 16'(row_d0[r])}, rd);
        wb_write(`MERGE_REG_DROPS, 32'hffff_ffff);
        wb_read(`MERGE_REG_DROPS, rd);
        check({name, " drops cleared"}, 32'd0, rd);

        // Empty DATA read
        wb_read(`MERGE_REG_STATUS, st);
        check({name, " status idle"}, 32'h0000_1000, st);   // Only output empty
        check({name, " full flags"}, 32'd0, 32'({ch1_full, ch0_full}));
        wb_read(`MERGE_REG_DATA, rd);
        check({name, " empty read"}, 32'd0, rd);
        wb_read(`MERGE_REG_STATUS, rd);
        check({name, " status kept"}, 32'h0000_1000, rd);
    endtask

    initial begin
        logic [31:0] rd;
        errors     = 0;
        checks     = 0;
        rst_n      = 1'b0;
        ch0_push   = 1'b0;
        ch1_push   = 1'b0;
        ch0_sample = '0;
        ch1_sample = '0;
        wb_req     = '0;
        rd         = $urandom(32'h4ea7_a579);   // Seed once
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Idle state after reset
        wb_read(`MERGE_REG_STATUS, rd);
        check("reset status", 32'h0000_1000, rd);
        wb_read(`MERGE_REG_DROPS, rd);
        check("reset drops", 32'd0, rd);

        for (int r = 0; r < N_ROWS; r++) begin
            run_row(r);
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- files.f
+incdir+hw
hw/merge_pkg.sv
hw/sync_fifo.sv
hw/rr_merge.sv
hw/wb_merge_regs.sv
hw/sample_merge_top.sv
bench/merge_tb.sv

//--- Bender.yml
package:
  name: sample_merge

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/merge_pkg.sv
      - hw/sync_fifo.sv
      - hw/rr_merge.sv
      - hw/wb_merge_regs.sv
      - hw/sample_merge_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - bench/merge_tb.sv
